/* vlog.f */
verilog/rename_pkg.sv
verilog/rename_if.sv
verilog/circular_queue.sv
verilog/rat.sv
verilog/rob.sv
verilog/rename_ctrl.sv
verilog/rename_core.sv
bench/rename_asserts.sv
bench/tb_rename_core.sv

/* Makefile */
TOP := tb_rename_core

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* bench/tb_rename_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rename_core;

    localparam int RESET_CYCLES   = 10;
    localparam int RENAME_CYCLES  = 300;
    localparam int DRAIN_CYCLES   = 80;
    localparam int STALL_CYCLES   = 30;
    localparam int RESUME_CYCLES  = 40;
    localparam int RECYCLE_CYCLES = 600;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + 1 + RENAME_CYCLES + 2 * DRAIN_CYCLES
                                    + STALL_CYCLES + RESUME_CYCLES + RECYCLE_CYCLES;

    logic                  clk;
    logic                  arst_n;
    logic                  inst_valid;
    rename_pkg::arch_reg_t inst_rd;
    rename_pkg::arch_reg_t inst_rs1;
    rename_pkg::arch_reg_t inst_rs2;
    logic                  inst_full;
    logic                  disp_valid;
    rename_pkg::rob_id_t   disp_rob_id;
    rename_pkg::preg_t     disp_prd;
    rename_pkg::preg_t     disp_prs1;
    rename_pkg::preg_t     disp_prs2;
    logic                  complete_valid;
    rename_pkg::rob_id_t   complete_rob_id;
    logic                  commit_valid;
    rename_pkg::arch_reg_t commit_rd;
    rename_pkg::preg_t     commit_prd;

    // Reference model state
    rename_pkg::preg_t     mrat [rename_pkg::ARCH_REGS];
    rename_pkg::preg_t     mfree [$];
    rename_pkg::inst_t     miq [$];
    rename_pkg::arch_reg_t rob_rd [$];
    rename_pkg::preg_t     rob_prd [$];
    rename_pkg::preg_t     rob_old [$];
    rename_pkg::rob_id_t   rob_id [$];
    logic                  rob_done [$];
    rename_pkg::rob_id_t   mtail;

    // Inputs decided at a falling edge, sampled by the DUT two edges on
    logic                  pend_push;
    rename_pkg::inst_t     pend_inst;
    logic                  pend_cpl;
    rename_pkg::rob_id_t   pend_id;

    // DUT outputs as seen at the last falling edge
    logic                  full_seen;

    int seed = 32'h497745e6;
    int errors = 0;
    int passed = 0;
    int failed = 0;
    int disp_total = 0;
    int dut_disp = 0;
    int alloc_total = 0;
    int x0_total = 0;
    int commit_total = 0;
    int start_errors;
    int mark;

    rename_core u_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    initial begin
        #(TOTAL_CYCLES * 4 * 20);
        $display("watchdog expired before all tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic report_error(input string msg);
        $display("error: %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic finish_test(input string name);
        if (errors == start_errors) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - start_errors);
            failed++;
        end
    endtask

    // One clock of checking and model update, then the next inputs
    task automatic step(input int push_pct, input int cpl_pct);
        rename_pkg::inst_t inst;
        rename_pkg::preg_t prd;
        rename_pkg::preg_t old;
        logic              exp_disp;
        logic              exp_commit;
        int                open_idx [$];
        @(negedge clk);
        full_seen  = inst_full;
        exp_disp   = miq.size() != 0 && rob_rd.size() < rename_pkg::ROB_DEPTH;
        exp_commit = rob_rd.size() != 0 && rob_done[0];
        assert (inst_full == (miq.size() == rename_pkg::IQ_DEPTH))
        else report_error($sformatf("inst_full is %0b, queue holds %0d", inst_full, miq.size()));
        assert (disp_valid == exp_disp)
        else report_error($sformatf("disp_valid is %0b, expected %0b", disp_valid, exp_disp));
        if (disp_valid) begin
            dut_disp++;
        end
        if (exp_disp) begin
            inst = miq.pop_front();
            prd  = (inst.rd != '0) ? mfree[0] : '0;
            assert (disp_rob_id == mtail && disp_prd == prd)
            else report_error($sformatf("dispatch rob id %0d prd %0d, expected %0d and %0d",
                                        disp_rob_id, disp_prd, mtail, prd));
            assert (disp_prs1 == mrat[inst.rs1] && disp_prs2 == mrat[inst.rs2])
            else report_error($sformatf("sources map to %0d %0d, expected %0d %0d", disp_prs1,
                                        disp_prs2, mrat[inst.rs1], mrat[inst.rs2]));
            old = mrat[inst.rd];
            if (inst.rd != '0) begin
                void'(mfree.pop_front());
                mrat[inst.rd] = prd;
                alloc_total++;
            end else begin
                x0_total++;
            end
            rob_rd.push_back(inst.rd);
            rob_prd.push_back(prd);
            rob_old.push_back(old);
            rob_id.push_back(mtail);
            rob_done.push_back(1'b0);
            mtail++;
            disp_total++;
        end
        assert (commit_valid == exp_commit)
        else report_error($sformatf("commit_valid is %0b, expected %0b", commit_valid, exp_commit));
        if (exp_commit) begin
            assert (commit_rd == rob_rd[0] && commit_prd == rob_prd[0])
            else report_error($sformatf("commit rd %0d prd %0d, expected %0d and %0d",
                                        commit_rd, commit_prd, rob_rd[0], rob_prd[0]));
            if (rob_rd[0] != '0) begin
                mfree.push_back(rob_old[0]);
            end
            void'(rob_rd.pop_front());
            void'(rob_prd.pop_front());
            void'(rob_old.pop_front());
            void'(rob_id.pop_front());
            void'(rob_done.pop_front());
            commit_total++;
        end
        // Inputs driven last cycle take effect at the coming edge
        if (pend_push) begin
            miq.push_back(pend_inst);
        end
        for (int i = 0; i < rob_id.size(); i++) begin
            if (pend_cpl && rob_id[i] == pend_id) begin
                rob_done[i] = 1'b1;
            end
        end
        pend_push = miq.size() < rename_pkg::IQ_DEPTH && rnd(100) < push_pct;
        pend_inst.rd  = (rnd(8) == 0) ? '0 : rename_pkg::arch_reg_t'(1 + rnd(31));
        pend_inst.rs1 = rename_pkg::arch_reg_t'(rnd(32));
        pend_inst.rs2 = rename_pkg::arch_reg_t'(rnd(32));
        for (int i = 0; i < rob_done.size(); i++) begin
            if (!rob_done[i]) begin
                open_idx.push_back(i);
            end
        end
        pend_cpl = open_idx.size() != 0 && rnd(100) < cpl_pct;
        pend_id  = pend_cpl ? rob_id[open_idx[rnd(open_idx.size())]] : '0;
        @(posedge clk);
        inst_valid      <= pend_push;
        inst_rd         <= pend_inst.rd;
        inst_rs1        <= pend_inst.rs1;
        inst_rs2        <= pend_inst.rs2;
        complete_valid  <= pend_cpl;
        complete_rob_id <= pend_id;
    endtask

    task automatic drain();
        repeat (DRAIN_CYCLES) step(0, 100);
        assert (rob_rd.size() == 0 && miq.size() == 0)
        else report_problem("pipeline did not drain with all completions given");
    endtask

    initial begin
        arst_n          = 1'b0;
        inst_valid      = 1'b0;
        inst_rd         = '0;
        inst_rs1        = '0;
        inst_rs2        = '0;
        complete_valid  = 1'b0;
        complete_rob_id = '0;
        pend_push       = 1'b0;
        pend_inst       = '0;
        pend_cpl        = 1'b0;
        pend_id         = '0;
        full_seen       = 1'b0;
        mtail           = '0;
        for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            mrat[i] = rename_pkg::preg_t'(i);
        end
        for (int i = 0; i < rename_pkg::PHYS_REGS - rename_pkg::ARCH_REGS; i++) begin
            mfree.push_back(rename_pkg::preg_t'(rename_pkg::ARCH_REGS + i));
        end

        start_errors = errors;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (!disp_valid && !commit_valid && !inst_full)
            else report_error("outputs not low during reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        step(0, 0);
        finish_test("reset_state");

        start_errors = errors;
        repeat (RENAME_CYCLES) step(70, 60);
        assert (x0_total > 0 && commit_total > 0)
        else report_problem("random run saw no x0 destination or no retirement");
        finish_test("rename_retire_random");

        start_errors = errors;
        drain();
        mark = dut_disp;
        repeat (STALL_CYCLES) step(100, 0);
        assert (dut_disp - mark == rename_pkg::ROB_DEPTH)
        else report_problem($sformatf("%0d dispatches with completions withheld",
                                      dut_disp - mark));
        assert (full_seen)
        else report_error("inst_full low with ROB and queue both full");
        mark = dut_disp;
        repeat (RESUME_CYCLES) step(100, 100);
        assert (dut_disp > mark)
        else report_problem("dispatch did not resume after completions");
        finish_test("back_pressure");

        start_errors = errors;
        mark = alloc_total;
        repeat (RECYCLE_CYCLES) step(90, 70);
        drain();
        assert (alloc_total - mark > 2 * (rename_pkg::PHYS_REGS - rename_pkg::ARCH_REGS))
        else report_problem("too few tag allocations to cycle the free list");
        finish_test("tag_recycling");

        $display("tests: %0d passed, %0d failed, %0d checks failed", passed, failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_rename_core

`default_nettype wire

/* bench/rename_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_asserts (
    input logic                                         clk,
    input logic                                         arst_n,
    input logic [$clog2(rename_pkg::ROB_DEPTH+1)-1:0]   rob_count,
    input rename_pkg::rob_id_t                          rob_head,
    input logic                                         free_empty,
    input logic                                         free_pop,
    input logic                                         disp_valid,
    input logic                                         complete_valid,
    input rename_pkg::rob_id_t                          complete_rob_id,
    input logic                                         commit_valid
);

    // Entries completed but not yet retired
    logic [rename_pkg::ROB_DEPTH-1:0] completed;

    // Entries dispatched and not yet retired, counted from the strobes
    int inflight;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            completed <= '0;
            inflight  <= 0;
        end else begin
            if (complete_valid) begin
                completed[complete_rob_id] <= 1'b1;
            end
            if (commit_valid) begin
                completed[rob_head] <= 1'b0;
            end
            inflight <= inflight + int'(disp_valid) - int'(commit_valid);
        end
    end

    a_rob_occupancy: assert property (@(posedge clk) disable iff (!arst_n)
        int'(rob_count) <= rename_pkg::ROB_DEPTH)
    else $error("ROB occupancy above its depth");

    a_free_tag: assert property (@(posedge clk) disable iff (!arst_n)
        free_pop |-> !free_empty)
    else $error("free list empty at a dispatch that needs a tag");

    a_disp_not_full: assert property (@(posedge clk) disable iff (!arst_n)
        disp_valid |-> inflight < rename_pkg::ROB_DEPTH)
    else $error("dispatch while the ROB is full");

    a_commit_completed: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid |-> completed[rob_head])
    else $error("retirement of an entry that was never completed");

endmodule : rename_asserts

bind rename_core rename_asserts u_asserts (
    .clk             (clk),
    .arst_n          (arst_n),
    .rob_count       (u_rob.count),
    .rob_head        (u_rob.head),
    .free_empty      (u_free_list.empty),
    .free_pop        (free_pop),
    .disp_valid      (disp_valid),
    .complete_valid  (complete_valid),
    .complete_rob_id (complete_rob_id),
    .commit_valid    (commit_valid)
);

`default_nettype wire

/* verilog/rename_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_core (
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  inst_valid,
    input  rename_pkg::arch_reg_t inst_rd,
    input  rename_pkg::arch_reg_t inst_rs1,
    input  rename_pkg::arch_reg_t inst_rs2,
    output logic                  inst_full,

    output logic                  disp_valid,
    output rename_pkg::rob_id_t   disp_rob_id,
    output rename_pkg::preg_t     disp_prd,
    output rename_pkg::preg_t     disp_prs1,
    output rename_pkg::preg_t     disp_prs2,

    input  logic                  complete_valid,
    input  rename_pkg::rob_id_t   complete_rob_id,

    output logic                  commit_valid,
    output rename_pkg::arch_reg_t commit_rd,
    output rename_pkg::preg_t     commit_prd
);

    rename_pkg::inst_t inst_in;
    rename_pkg::inst_t iq_head;
    logic              iq_empty;
    logic              iq_pop;

    rename_pkg::preg_t free_tag;
    logic              free_pop;
    logic              free_push;

    rename_pkg::preg_t old_prd;
    logic              rat_we;
    logic              rob_full;

    dispatch_if u_disp_if ();
    retire_if   u_ret_if ();

    assign inst_in = '{rd: inst_rd, rs1: inst_rs1, rs2: inst_rs2};

    circular_queue #(
        .payload_t (rename_pkg::inst_t),
        .DEPTH     (rename_pkg::IQ_DEPTH),
        .PRELOAD   (1'b0)
    ) u_inst_queue (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (inst_valid),
        .in     (inst_in),
        .pop    (iq_pop),
        .out    (iq_head),
        .empty  (iq_empty),
        .full   (inst_full)
    );

    // Holds every tag not mapped by the alias table or pending in the ROB
    circular_queue #(
        .payload_t (rename_pkg::preg_t),
        .DEPTH     (rename_pkg::PHYS_REGS - rename_pkg::ARCH_REGS),
        .PRELOAD   (1'b1)
    ) u_free_list (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (free_push),
        .in     (u_ret_if.old_preg),
        .pop    (free_pop),
        .out    (free_tag),
        .empty  (),
        .full   ()
    );

    // Lookups come straight from the queue head
    rat u_rat (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1     (iq_head.rs1),
        .rs2     (iq_head.rs2),
        .rd      (iq_head.rd),
        .prs1    (disp_prs1),
        .prs2    (disp_prs2),
        .old_prd (old_prd),
        .we      (rat_we),
        .new_prd (free_tag)
    );

    rob u_rob (
        .clk             (clk),
        .arst_n          (arst_n),
        .disp            (u_disp_if.rob),
        .complete_valid  (complete_valid),
        .complete_rob_id (complete_rob_id),
        .ret             (u_ret_if.rob),
        .full            (rob_full)
    );

    rename_ctrl u_rename_ctrl (
        .head_inst (iq_head),
        .iq_empty  (iq_empty),
        .rob_full  (rob_full),
        .iq_pop    (iq_pop),
        .free_tag  (free_tag),
        .free_pop  (free_pop),
        .rat_we    (rat_we),
        .old_prd   (old_prd),
        .disp      (u_disp_if.ctrl),
        .ret       (u_ret_if.sink),
        .free_push (free_push)
    );

    assign disp_valid  = u_disp_if.valid;
    assign disp_rob_id = u_disp_if.rob_id;
    assign disp_prd    = u_disp_if.new_preg;

    assign commit_valid = u_ret_if.valid;
    assign commit_rd    = u_ret_if.rd;
    assign commit_prd   = u_ret_if.new_preg;

endmodule : rename_core

`default_nettype wire

/* verilog/rename_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_ctrl (
    input  rename_pkg::inst_t head_inst,
    input  logic              iq_empty,
    input  logic              rob_full,
    output logic              iq_pop,
    input  rename_pkg::preg_t free_tag,
    output logic              free_pop,
    output logic              rat_we,
    input  rename_pkg::preg_t old_prd,
    dispatch_if.ctrl          disp,
    retire_if.sink            ret,
    output logic              free_push
);

    logic fire;
    logic has_rd;

    // One instruction per cycle whenever there is work and room
    assign fire   = !iq_empty && !rob_full;
    assign has_rd = head_inst.rd != '0;

    assign iq_pop = fire;

    // x0 destinations take no tag and leave the mapping alone
    assign free_pop = fire && has_rd;
    assign rat_we   = fire && has_rd;

    assign disp.valid    = fire;
    assign disp.rd       = head_inst.rd;
    assign disp.new_preg = has_rd ? free_tag : '0;
    assign disp.old_preg = has_rd ? old_prd : '0;

    // Old tag goes back to the free list on retirement
    assign free_push = ret.valid && ret.rd != '0;

endmodule : rename_ctrl

`default_nettype wire

/* verilog/rob.sv */
`timescale 1ns/100ps
`default_nettype none

module rob (
    input  logic                clk,
    input  logic                arst_n,
    dispatch_if.rob             disp,
    input  logic                complete_valid,
    input  rename_pkg::rob_id_t complete_rob_id,
    retire_if.rob               ret,
    output logic                full
);

    typedef logic [$clog2(rename_pkg::ROB_DEPTH+1)-1:0] cnt_t;

    // Entry payload
    rename_pkg::arch_reg_t rd_q  [rename_pkg::ROB_DEPTH];
    rename_pkg::preg_t     new_q [rename_pkg::ROB_DEPTH];
    rename_pkg::preg_t     old_q [rename_pkg::ROB_DEPTH];

    logic [rename_pkg::ROB_DEPTH-1:0] done_q;
    rename_pkg::rob_id_t              head;
    rename_pkg::rob_id_t              tail;
    cnt_t                             count;

    assign full        = count == cnt_t'(rename_pkg::ROB_DEPTH);
    assign disp.rob_id = tail;

    // Head leaves as soon as it is done
    assign ret.valid    = (count != '0) && done_q[head];
    assign ret.rd       = rd_q[head];
    assign ret.new_preg = new_q[head];
    assign ret.old_preg = old_q[head];

    always_ff @(posedge clk) begin
        if (disp.valid) begin
            rd_q[tail]  <= disp.rd;
            new_q[tail] <= disp.new_preg;
            old_q[tail] <= disp.old_preg;
        end
    end

    // Indices wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            if (complete_valid) begin
                done_q[complete_rob_id] <= 1'b1;
            end
            if (ret.valid) begin
                done_q[head] <= 1'b0;
                head         <= head + 1'b1;
            end
            // Fresh entry starts incomplete
            if (disp.valid) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            case ({disp.valid, ret.valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : rob

`default_nettype wire

/* verilog/rat.sv */
`timescale 1ns/100ps
`default_nettype none

module rat (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,
    input  rename_pkg::arch_reg_t rd,
    output rename_pkg::preg_t     prs1,
    output rename_pkg::preg_t     prs2,
    output rename_pkg::preg_t     old_prd,
    input  logic                  we,
    input  rename_pkg::preg_t     new_prd
);

    rename_pkg::preg_t map [rename_pkg::ARCH_REGS];

    // Source lookups and the mapping about to be replaced
    assign prs1    = map[rs1];
    assign prs2    = map[rs2];
    assign old_prd = map[rd];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Identity mapping, so x0 sits on tag 0 for good
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                map[i] <= rename_pkg::preg_t'(i);
            end
        end else if (we && rd != '0) begin
            map[rd] <= new_prd;
        end
    end

endmodule : rat

`default_nettype wire

/* verilog/circular_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module circular_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4,
    parameter bit  PRELOAD   = 1'b0
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t in,
    input  logic     pop,
    output payload_t out,
    output logic     empty,
    output logic     full
);

    typedef logic [$clog2(DEPTH)-1:0]   idx_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    payload_t mem [DEPTH];
    idx_t     head;
    idx_t     tail;
    cnt_t     count;
    logic     do_push;
    logic     do_pop;

    // Wrap explicitly so non power of two depths work too
    function automatic idx_t next_idx(idx_t idx);
        return (idx == idx_t'(DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    assign empty = count == '0;
    assign full  = count == cnt_t'(DEPTH);
    assign out   = mem[head];

    assign do_pop  = pop && !empty;
    // A full queue still accepts a push when the head leaves in the same cycle
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= PRELOAD ? cnt_t'(DEPTH) : '0;
        end else begin
            if (do_pop) begin
                head <= next_idx(head);
            end
            if (do_push) begin
                tail <= next_idx(tail);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    generate
        if (PRELOAD) begin : g_preload
            // Free list mode, tags above the architectural range start out free
            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        mem[i] <= payload_t'(rename_pkg::ARCH_REGS + i);
                    end
                end else if (do_push) begin
                    mem[tail] <= in;
                end
            end
        end else begin : g_plain
            always_ff @(posedge clk) begin
                if (do_push) begin
                    mem[tail] <= in;
                end
            end
        end
    endgenerate

endmodule : circular_queue

`default_nettype wire

/* verilog/rename_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Dispatch record from rename control into the ROB
interface dispatch_if;
    logic                  valid;
    rename_pkg::arch_reg_t rd;
    rename_pkg::preg_t     new_preg;
    rename_pkg::preg_t     old_preg;
    rename_pkg::rob_id_t   rob_id;

    // Tail index comes back from the ROB
    modport ctrl (
        output valid,
        output rd,
        output new_preg,
        output old_preg,
        input  rob_id
    );

    modport rob (
        input  valid,
        input  rd,
        input  new_preg,
        input  old_preg,
        output rob_id
    );
endinterface : dispatch_if

// Retirement record out of the ROB head
interface retire_if;
    logic                  valid;
    rename_pkg::arch_reg_t rd;
    rename_pkg::preg_t     new_preg;
    rename_pkg::preg_t     old_preg;

    modport rob (
        output valid,
        output rd,
        output new_preg,
        output old_preg
    );

    // Rename control only needs to know whether a tag is freed
    modport sink (
        input valid,
        input rd
    );
endinterface : retire_if

`default_nettype wire

/* verilog/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // Register file sizes
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    // Buffer depths
    localparam int ROB_DEPTH = 8;
    localparam int IQ_DEPTH  = 4;

    // Architectural register number
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;

    // Physical tag
    typedef logic [$clog2(PHYS_REGS)-1:0] preg_t;

    // Reorder buffer index
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_id_t;

    // Decoded instruction as held in the instruction queue
    typedef struct packed {
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } inst_t;

endpackage : rename_pkg

`default_nettype wire
